// ==== include/l2_cache_consts.svh ====
`ifndef L2_CACHE_CONSTS_SVH
`define L2_CACHE_CONSTS_SVH

// ----------------------------------------
// addressing
// ----------------------------------------
`define L2_BW_WORD_ADDR 24 // word address into main memory
`define L2_BW_BLOCK     2  // word offset inside a block
`define L2_BLOCK_WORDS  4

// ----------------------------------------
// cache geometry
// ----------------------------------------
`define L2_LINES        8  // fully associative, all lines searched
`define L2_BW_LINE      3
`define L2_BW_DATA      32

`endif

// ==== hw/l2_addr_pkg.sv ====
`include "l2_cache_consts.svh"

package l2_addr_pkg;

	// block tag is the word address without the word offset
	typedef logic [`L2_BW_WORD_ADDR-`L2_BW_BLOCK-1:0] l2_tag_t;
	typedef logic [`L2_BW_LINE-1:0]                   l2_line_t;
	typedef logic [`L2_BW_BLOCK-1:0]                  l2_offset_t;

	// one L1 word address, seen flat or as tag + offset
	typedef union packed {
		logic [`L2_BW_WORD_ADDR-1:0] flat; // as sent to memory
		struct packed {
			l2_tag_t    tag;    // cam key
			l2_offset_t offset; // word in block
		} part;
	} l2_word_addr_u;

	// word address inside the cache data array
	typedef struct packed {
		l2_line_t   line;
		l2_offset_t offset;
	} l2_cache_addr_t;

endpackage

// ==== hw/l2_ctrl_pkg.sv ====
package l2_ctrl_pkg;

	// block controller states
	typedef enum logic [3:0] {
		ST_NORMAL       = 4'd0, // lookup, hit or miss
		ST_WAIT_READY   = 4'd1, // fill command not yet sent
		ST_REPLACE      = 4'd2, // victim chosen, check dirty
		ST_WRITE_BUFFER = 4'd3, // victim block -> write buffer
		ST_READ_BUFFER  = 4'd4, // fill from read buffer or L1
		ST_TO_L1        = 4'd5, // read hit, stream out
		ST_FROM_L1      = 4'd6, // write hit, stream in
		ST_TAG_WAIT     = 4'd7  // cam takes the new tag
	} l2_state_e;

	// block command kind on the memory port
	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} l2_mem_cmd_e;

endpackage

// ==== hw/l2_tag_cam.sv ====
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

module l2_tag_cam
	import l2_addr_pkg::*;
(
	input  logic     clock_i,
	input  logic     resetn_i,
	input  l2_tag_t  lookup_tag_i, // tag of the current L1 address
	input  logic     write_i,      // end of a fill
	input  l2_line_t write_line_i,
	input  l2_line_t read_line_i,  // line being evicted
	output logic     hit_o,
	output l2_line_t hit_line_o,
	output l2_tag_t  read_tag_o
);

	l2_tag_t              tag_q [`L2_LINES];
	logic [`L2_LINES-1:0] valid_q;

	// ----------------------------------------
	// valid bits
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0; // empty cache after reset
		end else if (write_i) begin
			valid_q[write_line_i] <= 1'b1;
		end
	end

	// tag storage, lookup tag becomes the stored tag
	always_ff @(posedge clock_i) begin
		if (write_i) begin
			tag_q[write_line_i] <= lookup_tag_i;
		end
	end

	// ----------------------------------------
	// parallel compare + encode
	// ----------------------------------------
	always_comb begin
		hit_o      = 1'b0;
		hit_line_o = '0;
		for (int i = 0; i < `L2_LINES; i++) begin
			if (valid_q[i] && (tag_q[i] == lookup_tag_i)) begin
				hit_o      = 1'b1;
				hit_line_o = l2_line_t'(i); // at most one match
			end
		end
	end

	// old tag for the writeback base
	assign read_tag_o = tag_q[read_line_i];

endmodule

// ==== hw/l2_line_store.sv ====
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

module l2_line_store
	import l2_addr_pkg::*;
(
	input  logic                   clock_i,
	input  l2_cache_addr_t         addr_i,
	input  logic                   wren_i,
	input  logic [`L2_BW_DATA-1:0] wdata_i,
	output logic [`L2_BW_DATA-1:0] rdata_o
);

	localparam int unsigned DEPTH = `L2_LINES * `L2_BLOCK_WORDS;

	// cache data ram, one word per line/offset pair
	logic [`L2_BW_DATA-1:0] mem_q [DEPTH];
	logic [`L2_BW_DATA-1:0] rdata_q;

	// ----------------------------------------
	// write port
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			mem_q[addr_i] <= wdata_i; // line index in the upper bits
		end
	end

	// ----------------------------------------
	// read port
	// ----------------------------------------
	// registered, word is out one cycle after addr
	// read during write returns the old word
	always_ff @(posedge clock_i) begin
		rdata_q <= mem_q[addr_i];
	end

	assign rdata_o = rdata_q;

endmodule

// ==== hw/l2_block_sequencer.sv ====
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

module l2_block_sequencer
	import l2_addr_pkg::*;
	import l2_ctrl_pkg::*;
(
	input  logic                        clock_i,
	input  logic                        resetn_i,
	// L1 side
	input  logic                        l1_req_i,
	input  logic                        l1_rw_i,   // 1 = write
	input  l2_word_addr_u               l1_addr_i,
	input  logic [`L2_BW_DATA-1:0]      l1_data_i,
	input  logic                        l1_ready_write_i,
	input  logic                        l1_ready_read_i,
	output logic                        l1_done_o,
	output logic                        l1_hit_o,
	output logic [`L2_BW_DATA-1:0]      l1_data_o,
	output logic                        l1_valid_o,
	output logic                        l1_read_ack_o,
	// tag cam
	input  logic                        cam_hit_i,
	input  l2_line_t                    cam_line_i,
	input  l2_tag_t                     cam_tag_i,
	output logic                        cam_write_o,
	output l2_line_t                    cam_read_line_o,
	// data array
	output l2_cache_addr_t              store_addr_o,
	output logic                        store_wren_o,
	output logic [`L2_BW_DATA-1:0]      store_wdata_o,
	input  logic [`L2_BW_DATA-1:0]      store_rdata_i,
	// memory buffers
	input  logic                        buffer_read_ready_i,
	input  logic [`L2_BW_DATA-1:0]      buffer_read_data_i,
	output logic                        buffer_read_ack_o,
	input  logic                        buffer_write_ready_i,
	output logic [`L2_BW_DATA-1:0]      buffer_write_data_o,
	output logic                        buffer_write_ack_o,
	// writeback issuer
	output logic                        fill_req_o,
	output logic [`L2_BW_WORD_ADDR-1:0] fill_addr_o,
	input  logic                        fill_sent_i,
	output logic                        wb_start_o,
	output logic [`L2_BW_WORD_ADDR-1:0] wb_addr_o
);

	l2_state_e            state_q;
	logic [`L2_BW_BLOCK:0] cnt_q;     // words moved, one extra bit for the done step
	logic [`L2_LINES-1:0] dirty_q;
	l2_line_t             victim_q;  // round robin pointer
	l2_line_t             line_q;    // line being worked on
	logic                 req_q;     // request waiting for replay after a miss
	logic                 rw_q;
	logic                 done_q;

	logic     hit_rw;
	logic     last_word;
	logic     l1_take;
	logic     buf_take;
	l2_line_t victim_nxt;

	// block base, offset cleared through the tag view
	function automatic logic [`L2_BW_WORD_ADDR-1:0] block_base(input l2_tag_t tag);
		l2_word_addr_u a;
		a.part.tag    = tag;
		a.part.offset = '0;
		return a.flat;
	endfunction

	assign hit_rw     = req_q ? rw_q : l1_rw_i; // replayed miss keeps its own kind
	assign last_word  = (cnt_q == `L2_BLOCK_WORDS - 1);
	assign victim_nxt = victim_q + 1'b1;

	// words accepted this cycle
	assign l1_take  = l1_ready_read_i && (((state_q == ST_FROM_L1) && !cnt_q[`L2_BW_BLOCK])
		|| ((state_q == ST_READ_BUFFER) && rw_q));
	assign buf_take = buffer_read_ready_i && (state_q == ST_READ_BUFFER) && !rw_q;

	// ----------------------------------------
	// data path
	// ----------------------------------------
	assign store_addr_o.line   = line_q;
	assign store_addr_o.offset = cnt_q[`L2_BW_BLOCK-1:0];
	assign store_wren_o        = l1_take | buf_take;
	assign store_wdata_o       = buf_take ? buffer_read_data_i : l1_data_i;
	assign buffer_read_ack_o   = buf_take; // pop on the same edge the word is taken

	// store read lags one cycle, matches the registered strobes
	assign l1_data_o           = store_rdata_i;
	assign buffer_write_data_o = store_rdata_i;

	assign cam_read_line_o = line_q; // old tag of the victim
	assign l1_done_o       = done_q;
	assign l1_hit_o        = (l1_req_i | req_q) ? cam_hit_i : 1'b1; // no stall when idle

	// ----------------------------------------
	// controller
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q            <= ST_NORMAL;
			cnt_q              <= '0;
			dirty_q            <= '0;
			victim_q           <= '1; // first miss rolls to line 0
			line_q             <= '0;
			req_q              <= 1'b0;
			rw_q               <= 1'b0;
			done_q             <= 1'b1; // ready right after reset
			l1_valid_o         <= 1'b0;
			l1_read_ack_o      <= 1'b0;
			buffer_write_ack_o <= 1'b0;
			cam_write_o        <= 1'b0;
			fill_req_o         <= 1'b0;
			wb_start_o         <= 1'b0;
		end else begin
			// strobes default low
			l1_valid_o         <= 1'b0;
			l1_read_ack_o      <= l1_take;
			buffer_write_ack_o <= 1'b0;
			cam_write_o        <= 1'b0;
			fill_req_o         <= 1'b0;
			wb_start_o         <= 1'b0;
			if (l1_take | buf_take) cnt_q <= cnt_q + 1'b1;

			case (state_q)
				ST_NORMAL: begin
					if (l1_req_i | req_q) begin
						done_q <= 1'b0; // stall L1
						if (cam_hit_i) begin
							req_q   <= 1'b0;
							rw_q    <= hit_rw;
							line_q  <= cam_line_i;
							cnt_q   <= '0;
							state_q <= hit_rw ? ST_FROM_L1 : ST_TO_L1;
							if (hit_rw) dirty_q[cam_line_i] <= 1'b1;
						end else begin
							req_q    <= 1'b1;
							rw_q     <= l1_rw_i;
							victim_q <= victim_nxt;
							line_q   <= victim_nxt;
							state_q  <= ST_REPLACE;
						end
					end
				end
				ST_REPLACE: begin
					cnt_q <= '0;
					if (dirty_q[line_q]) begin
						state_q <= ST_WRITE_BUFFER;
					end else begin
						fill_req_o <= !rw_q; // write miss fetches nothing
						state_q    <= rw_q ? ST_READ_BUFFER : ST_WAIT_READY;
					end
				end
				ST_WRITE_BUFFER: begin
					if (buffer_write_ready_i) begin
						buffer_write_ack_o <= 1'b1;
						cnt_q              <= cnt_q + 1'b1;
						if (last_word) begin
							cnt_q           <= '0;
							wb_start_o      <= 1'b1; // whole block is in the buffer
							dirty_q[line_q] <= 1'b0;
							fill_req_o      <= !rw_q;
							state_q         <= rw_q ? ST_READ_BUFFER : ST_WAIT_READY;
						end
					end
				end
				ST_WAIT_READY: if (fill_sent_i) state_q <= ST_READ_BUFFER;
				ST_READ_BUFFER: begin
					if ((l1_take | buf_take) && last_word) begin
						cnt_q       <= '0;
						cam_write_o <= 1'b1;
						state_q     <= ST_TAG_WAIT;
						if (rw_q) begin
							dirty_q[line_q] <= 1'b1;
							req_q           <= 1'b0; // write miss is complete
						end
					end
				end
				ST_TAG_WAIT: begin
					state_q <= ST_NORMAL;
					if (!req_q) done_q <= 1'b1; // read miss replays as a hit instead
				end
				ST_TO_L1: begin
					if (cnt_q == `L2_BLOCK_WORDS) begin
						cnt_q   <= '0;
						done_q  <= 1'b1;
						state_q <= ST_NORMAL;
					end else if (l1_ready_write_i) begin
						l1_valid_o <= 1'b1;
						cnt_q      <= cnt_q + 1'b1;
					end
				end
				ST_FROM_L1: begin
					if (cnt_q == `L2_BLOCK_WORDS) begin
						cnt_q   <= '0;
						done_q  <= 1'b1;
						state_q <= ST_NORMAL;
					end
				end
				default: state_q <= ST_NORMAL;
			endcase
		end
	end

	// addresses for the issuer, valid with their strobes
	always_ff @(posedge clock_i) begin
		if ((state_q == ST_REPLACE) || (state_q == ST_WRITE_BUFFER)) begin
			fill_addr_o <= block_base(l1_addr_i.part.tag);
		end
		if (state_q == ST_WRITE_BUFFER) begin
			wb_addr_o <= block_base(cam_tag_i); // tag not yet replaced
		end
	end

endmodule

// ==== hw/l2_writeback_issue.sv ====
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

module l2_writeback_issue
	import l2_ctrl_pkg::*;
(
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic                        mem_ready_i,
	input  logic                        wb_start_i,
	input  logic [`L2_BW_WORD_ADDR-1:0] wb_addr_i,
	input  logic                        fill_req_i,
	input  logic [`L2_BW_WORD_ADDR-1:0] fill_addr_i,
	output logic                        fill_sent_o,
	output logic                        mem_req_o,
	output logic                        mem_rw_o,
	output logic [`L2_BW_WORD_ADDR-1:0] mem_addr_o
);

	logic                        wb_pend_q;
	logic                        fill_pend_q;
	logic [`L2_BW_WORD_ADDR-1:0] wb_addr_q;
	logic [`L2_BW_WORD_ADDR-1:0] fill_addr_q;
	l2_mem_cmd_e                 cmd_q;
	logic                        issue;

	// one gap cycle after each command so memory can drop ready
	assign issue    = mem_ready_i && !mem_req_o && (wb_pend_q || fill_pend_q);
	assign mem_rw_o = (cmd_q == MEM_WRITE);

	// ----------------------------------------
	// pending commands, writeback first
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wb_pend_q   <= 1'b0;
			fill_pend_q <= 1'b0;
			mem_req_o   <= 1'b0;
			fill_sent_o <= 1'b0;
		end else begin
			mem_req_o   <= issue;
			fill_sent_o <= issue && !wb_pend_q;
			if (issue) begin
				if (wb_pend_q) wb_pend_q <= 1'b0;
				else fill_pend_q <= 1'b0;
			end
			if (wb_start_i) wb_pend_q <= 1'b1;
			if (fill_req_i) fill_pend_q <= 1'b1;
		end
	end

	// command payload
	always_ff @(posedge clock_i) begin
		if (wb_start_i) wb_addr_q <= wb_addr_i;
		if (fill_req_i) fill_addr_q <= fill_addr_i;
		if (issue) begin
			cmd_q      <= wb_pend_q ? MEM_WRITE : MEM_READ;
			mem_addr_o <= wb_pend_q ? wb_addr_q : fill_addr_q; // block base
		end
	end

endmodule

// ==== hw/l2_cache_top.sv ====
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

module l2_cache_top
	import l2_addr_pkg::*;
(
	input  logic                        clock_i,
	input  logic                        resetn_i,
	// L1 side
	input  logic                        l1_req_i,
	input  logic                        l1_rw_i,
	input  l2_word_addr_u               l1_addr_i,
	input  logic [`L2_BW_DATA-1:0]      l1_data_i,
	input  logic                        l1_ready_write_i,
	input  logic                        l1_ready_read_i,
	output logic                        l1_done_o,
	output logic                        l1_hit_o,
	output logic [`L2_BW_DATA-1:0]      l1_data_o,
	output logic                        l1_valid_o,
	output logic                        l1_read_ack_o,
	// memory buffers
	input  logic                        buffer_read_ready_i,
	input  logic [`L2_BW_DATA-1:0]      buffer_read_data_i,
	output logic                        buffer_read_ack_o,
	input  logic                        buffer_write_ready_i,
	output logic [`L2_BW_DATA-1:0]      buffer_write_data_o,
	output logic                        buffer_write_ack_o,
	// memory command
	input  logic                        mem_ready_i,
	output logic                        mem_req_o,
	output logic                        mem_rw_o,
	output logic [`L2_BW_WORD_ADDR-1:0] mem_addr_o
);

	// ----------------------------------------
	// internal wires
	// ----------------------------------------
	logic                        cam_hit, cam_write;
	l2_line_t                    cam_line, cam_read_line;
	l2_tag_t                     cam_tag;
	l2_cache_addr_t              store_addr;
	logic                        store_wren;
	logic [`L2_BW_DATA-1:0]      store_wdata, store_rdata;
	logic                        fill_req, fill_sent, wb_start;
	logic [`L2_BW_WORD_ADDR-1:0] fill_addr, wb_addr;

	l2_tag_cam u_cam (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.lookup_tag_i(l1_addr_i.part.tag), // tag view of the L1 address
		.write_i(cam_write),
		.write_line_i(cam_read_line), // victim line, same for read and write
		.read_line_i(cam_read_line),
		.hit_o(cam_hit), .hit_line_o(cam_line), .read_tag_o(cam_tag)
	);

	l2_line_store u_store (
		.clock_i(clock_i), .addr_i(store_addr), .wren_i(store_wren),
		.wdata_i(store_wdata), .rdata_o(store_rdata)
	);

	l2_block_sequencer u_seq (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.l1_req_i(l1_req_i), .l1_rw_i(l1_rw_i), .l1_addr_i(l1_addr_i), .l1_data_i(l1_data_i),
		.l1_ready_write_i(l1_ready_write_i), .l1_ready_read_i(l1_ready_read_i),
		.l1_done_o(l1_done_o), .l1_hit_o(l1_hit_o), .l1_data_o(l1_data_o),
		.l1_valid_o(l1_valid_o), .l1_read_ack_o(l1_read_ack_o),
		.cam_hit_i(cam_hit), .cam_line_i(cam_line), .cam_tag_i(cam_tag),
		.cam_write_o(cam_write), .cam_read_line_o(cam_read_line),
		.store_addr_o(store_addr), .store_wren_o(store_wren),
		.store_wdata_o(store_wdata), .store_rdata_i(store_rdata),
		.buffer_read_ready_i(buffer_read_ready_i), .buffer_read_data_i(buffer_read_data_i),
		.buffer_read_ack_o(buffer_read_ack_o), .buffer_write_ready_i(buffer_write_ready_i),
		.buffer_write_data_o(buffer_write_data_o), .buffer_write_ack_o(buffer_write_ack_o),
		.fill_req_o(fill_req), .fill_addr_o(fill_addr), .fill_sent_i(fill_sent),
		.wb_start_o(wb_start), .wb_addr_o(wb_addr)
	);

	l2_writeback_issue u_issue (
		.clock_i(clock_i), .resetn_i(resetn_i), .mem_ready_i(mem_ready_i),
		.wb_start_i(wb_start), .wb_addr_i(wb_addr),
		.fill_req_i(fill_req), .fill_addr_i(fill_addr), .fill_sent_o(fill_sent),
		.mem_req_o(mem_req_o), .mem_rw_o(mem_rw_o), .mem_addr_o(mem_addr_o)
	);

endmodule

// ==== dv/l2_mem_model.sv ====
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

module l2_mem_model (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic                        mem_req_i,
	input  logic                        mem_rw_i,
	input  logic [`L2_BW_WORD_ADDR-1:0] mem_addr_i,
	output logic                        mem_ready_o,
	output logic                        buffer_read_ready_o,
	output logic [`L2_BW_DATA-1:0]      buffer_read_data_o,
	input  logic                        buffer_read_ack_i,
	output logic                        buffer_write_ready_o,
	input  logic [`L2_BW_DATA-1:0]      buffer_write_data_i,
	input  logic                        buffer_write_ack_i,
	input  logic [2:0]                  stall_i,  // random back-pressure from the testbench
	output int                          rd_cmds_o,
	output int                          wr_cmds_o,
	output logic                        error_o
);

	localparam int WORDS = 4096;

	logic [`L2_BW_DATA-1:0] mem [WORDS];
	logic                   written [WORDS];
	logic [`L2_BW_DATA-1:0] rd_q [$]; // read buffer, head feeds the cache
	logic [`L2_BW_DATA-1:0] wr_q [$]; // write buffer
	int                     busy_q;
	logic                   idle_q;
	logic                   avail_q;
	logic [`L2_BW_DATA-1:0] head_q;

	// untouched words carry their own address
	function automatic logic [`L2_BW_DATA-1:0] word_at(input logic [`L2_BW_WORD_ADDR-1:0] a);
		if (written[a[11:0]]) return mem[a[11:0]];
		return {8'ha5, a};
	endfunction

	initial begin
		for (int i = 0; i < WORDS; i++) written[i] = 1'b0;
		idle_q  = 1'b0;
		avail_q = 1'b0;
		head_q  = '0;
	end

	// ----------------------------------------
	// commands and buffer traffic, posedge
	// ----------------------------------------
	always @(posedge clock_i) begin
		if (!resetn_i) begin
			rd_q.delete();
			wr_q.delete();
			busy_q    = 0;
			rd_cmds_o = 0;
			wr_cmds_o = 0;
			error_o   = 1'b0;
		end else begin
			if (buffer_read_ack_i) begin
				if (rd_q.size() == 0) error_o = 1'b1; // pop from empty buffer
				else void'(rd_q.pop_front());
			end
			if (buffer_write_ack_i) wr_q.push_back(buffer_write_data_i);
			if (mem_req_i) begin
				if (mem_rw_i) begin
					wr_cmds_o++;
					if (wr_q.size() < `L2_BLOCK_WORDS) begin
						error_o = 1'b1; // block not fully buffered
					end else begin
						for (int k = 0; k < `L2_BLOCK_WORDS; k++) begin
							mem[mem_addr_i[11:0] + k]     = wr_q.pop_front();
							written[mem_addr_i[11:0] + k] = 1'b1;
						end
					end
					busy_q = 3; // short write burst
				end else begin
					rd_cmds_o++;
					if (wr_q.size() != 0) error_o = 1'b1; // fill overtook writeback
					for (int k = 0; k < `L2_BLOCK_WORDS; k++) rd_q.push_back(word_at(mem_addr_i + k));
				end
			end
		end
	end

	// outputs move on the falling edge only
	always @(negedge clock_i) begin
		if (busy_q > 0) busy_q--;
		idle_q  = resetn_i && (rd_q.size() == 0) && (busy_q == 0);
		avail_q = (rd_q.size() > 0);
		head_q  = avail_q ? rd_q[0] : '0;
	end

	assign mem_ready_o          = idle_q && !stall_i[2];
	assign buffer_read_ready_o  = avail_q && !stall_i[0];
	assign buffer_read_data_o   = head_q;
	assign buffer_write_ready_o = !stall_i[1];

endmodule

// ==== dv/l2_cache_tb.sv ====
`timescale 1ns/1ps
`include "l2_cache_consts.svh"

module l2_cache_tb;

	localparam int MAX_OPS       = 64;
	localparam int FIELDS        = 8; // op addr w0..w3 hit memwr
	localparam int CYCLES_PER_OP = 200;

	logic                        clock, resetn;
	logic                        l1_req, l1_rw, l1_ready_write, l1_ready_read;
	logic [`L2_BW_WORD_ADDR-1:0] l1_addr;
	logic [`L2_BW_DATA-1:0]      l1_data;
	logic                        l1_done, l1_hit, l1_valid, l1_read_ack;
	logic [`L2_BW_DATA-1:0]      l1_data_o;
	logic                        buf_rd_ready, buf_rd_ack, buf_wr_ready, buf_wr_ack;
	logic [`L2_BW_DATA-1:0]      buf_rd_data, buf_wr_data;
	logic                        mem_ready, mem_req, mem_rw;
	logic [`L2_BW_WORD_ADDR-1:0] mem_addr;
	logic [2:0]                  mem_stall;
	int                          mem_rd_cmds, mem_wr_cmds;
	logic                        mem_error;

	logic [31:0]            trace_mem [MAX_OPS*FIELDS];
	logic [`L2_BW_DATA-1:0] wr_block [`L2_BLOCK_WORDS]; // words of the current op
	logic [`L2_BW_DATA-1:0] rd_words [$];               // words seen on l1_data_o
	int                     ack_cnt, cycle_cnt, cycle_limit, n_ops;
	logic [31:0]            rnd;

	l2_cache_top u_dut (
		.clock_i(clock), .resetn_i(resetn),
		.l1_req_i(l1_req), .l1_rw_i(l1_rw), .l1_addr_i(l1_addr), .l1_data_i(l1_data),
		.l1_ready_write_i(l1_ready_write), .l1_ready_read_i(l1_ready_read),
		.l1_done_o(l1_done), .l1_hit_o(l1_hit), .l1_data_o(l1_data_o),
		.l1_valid_o(l1_valid), .l1_read_ack_o(l1_read_ack),
		.buffer_read_ready_i(buf_rd_ready), .buffer_read_data_i(buf_rd_data),
		.buffer_read_ack_o(buf_rd_ack), .buffer_write_ready_i(buf_wr_ready),
		.buffer_write_data_o(buf_wr_data), .buffer_write_ack_o(buf_wr_ack),
		.mem_ready_i(mem_ready), .mem_req_o(mem_req), .mem_rw_o(mem_rw), .mem_addr_o(mem_addr)
	);

	l2_mem_model u_mem (
		.clock_i(clock), .resetn_i(resetn),
		.mem_req_i(mem_req), .mem_rw_i(mem_rw), .mem_addr_i(mem_addr), .mem_ready_o(mem_ready),
		.buffer_read_ready_o(buf_rd_ready), .buffer_read_data_o(buf_rd_data),
		.buffer_read_ack_i(buf_rd_ack), .buffer_write_ready_o(buf_wr_ready),
		.buffer_write_data_i(buf_wr_data), .buffer_write_ack_i(buf_wr_ack),
		.stall_i(mem_stall), .rd_cmds_o(mem_rd_cmds), .wr_cmds_o(mem_wr_cmds), .error_o(mem_error)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock; // 4 ns period
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped");
	endtask

	// ----------------------------------------
	// one clock step, falling edge
	// ----------------------------------------
	task automatic next_cycle();
		@(negedge clock);
		cycle_cnt++;
		assert (cycle_cnt <= cycle_limit) else
			abort_run($sformatf("timeout: no completion within %0d cycles", cycle_limit));
		assert (!mem_error) else abort_run("memory model saw a short block or a fill before a writeback");
		if (l1_valid) rd_words.push_back(l1_data_o); // one pulse per word
		if (l1_read_ack) ack_cnt++;                  // ack lags the take by one cycle
		if (ack_cnt < `L2_BLOCK_WORDS) l1_data = wr_block[ack_cnt];
		rnd            = xorshift32(rnd);
		l1_ready_write = (rnd[1:0] != 2'd0); // low about one cycle in four
		l1_ready_read  = (rnd[3:2] != 2'd0);
		mem_stall      = {rnd[9:8] == 2'd0, rnd[7:6] == 2'd0, rnd[5:4] == 2'd0};
	endtask

	task automatic run_op(input int idx);
		int          base;
		int          rd_before;
		int          wr_before;
		logic [31:0] op;
		logic [31:0] exp_hit;
		logic [31:0] exp_wr;
		base    = idx * FIELDS;
		op      = trace_mem[base];
		exp_hit = trace_mem[base+6];
		exp_wr  = trace_mem[base+7];
		while (!l1_done) next_cycle();
		for (int k = 0; k < `L2_BLOCK_WORDS; k++) wr_block[k] = trace_mem[base+2+k];
		rd_words.delete();
		ack_cnt   = 0;
		rd_before = mem_rd_cmds;
		wr_before = mem_wr_cmds;
		l1_req    = 1'b1;
		l1_rw     = op[0];
		l1_addr   = trace_mem[base+1][`L2_BW_WORD_ADDR-1:0]; // held for the whole op
		l1_data   = wr_block[0];
		#1;
		assert (l1_hit === exp_hit[0]) else
			abort_run($sformatf("error at %0t: op %0d hit %b, expected %b", $time, idx, l1_hit, exp_hit[0]));
		next_cycle();
		l1_req = 1'b0;
		assert (l1_done === 1'b0) else
			abort_run($sformatf("error at %0t: op %0d l1_done_o stayed high", $time, idx));
		while (!l1_done) next_cycle();
		if (op[0]) begin
			assert (ack_cnt == `L2_BLOCK_WORDS) else
				abort_run($sformatf("error at %0t: op %0d took %0d words", $time, idx, ack_cnt));
		end else begin
			assert (rd_words.size() == `L2_BLOCK_WORDS) else
				abort_run($sformatf("error at %0t: op %0d gave %0d words", $time, idx, rd_words.size()));
			for (int k = 0; k < `L2_BLOCK_WORDS; k++) begin
				assert (rd_words[k] === wr_block[k]) else
					abort_run($sformatf("error at %0t: op %0d word %0d is %h, expected %h",
						$time, idx, k, rd_words[k], wr_block[k]));
			end
		end
		// only a read miss fetches from memory
		assert (mem_rd_cmds - rd_before == ((!op[0] && !exp_hit[0]) ? 1 : 0)) else
			abort_run($sformatf("error at %0t: op %0d wrong memory read count", $time, idx));
		assert (mem_wr_cmds - wr_before == exp_wr) else
			abort_run($sformatf("error at %0t: op %0d wrong memory write count", $time, idx));
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		resetn         = 1'b0;
		l1_req         = 1'b0;
		l1_rw          = 1'b0;
		l1_addr        = '0;
		l1_data        = '0;
		l1_ready_write = 1'b1;
		l1_ready_read  = 1'b1;
		mem_stall      = '0;
		rnd            = 32'he182e874;
		cycle_cnt      = 0;
		ack_cnt        = 0;
		for (int i = 0; i < MAX_OPS*FIELDS; i++) trace_mem[i] = '1; // end marker
		for (int k = 0; k < `L2_BLOCK_WORDS; k++) wr_block[k] = '0;
		$readmemh("dv/l2_trace.txt", trace_mem);
		n_ops = 0;
		while ((n_ops < MAX_OPS) && (trace_mem[n_ops*FIELDS] !== 32'hffffffff)) n_ops++;
		cycle_limit = n_ops * CYCLES_PER_OP + 32;
		assert (n_ops > 0) else abort_run("trace file is missing or holds no operations");
		repeat (16) next_cycle();
		resetn = 1'b1;
		next_cycle();
		assert ((l1_done === 1'b1) && (mem_req === 1'b0)) else
			abort_run($sformatf("error at %0t: wrong outputs after reset", $time));
		for (int i = 0; i < n_ops; i++) run_op(i);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+include
hw/l2_addr_pkg.sv
hw/l2_ctrl_pkg.sv
hw/l2_tag_cam.sv
hw/l2_line_store.sv
hw/l2_block_sequencer.sv
hw/l2_writeback_issue.sv
hw/l2_cache_top.sv
dv/l2_mem_model.sv
dv/l2_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l2_cache

sources:
  - include_dirs:
      - include
    files:
      - hw/l2_addr_pkg.sv
      - hw/l2_ctrl_pkg.sv
      - hw/l2_tag_cam.sv
      - hw/l2_line_store.sv
      - hw/l2_block_sequencer.sv
      - hw/l2_writeback_issue.sv
      - hw/l2_cache_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/l2_mem_model.sv
      - dv/l2_cache_tb.sv

// ==== dv/l2_trace.txt ====
// op(0 read, 1 write) block_addr word0 word1 word2 word3 exp_hit exp_mem_write
// read: words are expected data, write: words are driven data
0 000040 a5000040 a5000041 a5000042 a5000043 0 0
0 000040 a5000040 a5000041 a5000042 a5000043 1 0
1 000040 11110000 11110001 11110002 11110003 1 0
0 000040 11110000 11110001 11110002 11110003 1 0
1 000100 22220000 22220001 22220002 22220003 0 0
0 000100 22220000 22220001 22220002 22220003 1 0
0 000200 a5000200 a5000201 a5000202 a5000203 0 0
0 000300 a5000300 a5000301 a5000302 a5000303 0 0
0 000400 a5000400 a5000401 a5000402 a5000403 0 0
0 000500 a5000500 a5000501 a5000502 a5000503 0 0
0 000600 a5000600 a5000601 a5000602 a5000603 0 0
0 000700 a5000700 a5000701 a5000702 a5000703 0 0
0 000800 a5000800 a5000801 a5000802 a5000803 0 1
0 000040 11110000 11110001 11110002 11110003 0 1
0 000100 22220000 22220001 22220002 22220003 0 0
1 000200 33330000 33330001 33330002 33330003 0 0
0 000200 33330000 33330001 33330002 33330003 1 0
1 000300 44440000 44440001 44440002 44440003 0 0
0 000800 a5000800 a5000801 a5000802 a5000803 1 0
0 000500 a5000500 a5000501 a5000502 a5000503 1 0
1 000500 55550000 55550001 55550002 55550003 1 0
0 000900 a5000900 a5000901 a5000902 a5000903 0 1
0 000500 55550000 55550001 55550002 55550003 0 0
0 000700 a5000700 a5000701 a5000702 a5000703 1 0
